// File: source/pid_pkg.sv
package pid_pkg;

	////////////////////////////////////////////////////////////////////////////
	// loop dimensions
	////////////////////////////////////////////////////////////////////////////
	localparam int N_CH     = 2;	// pid channels, channel i feeds dac channel i
	localparam int W_SAMPLE = 18;	// converted adc word
	localparam int W_EP     = 16;	// config port word
	localparam int W_COMP   = 64;	// pid sum and integral
	localparam int W_MLT    = 10;	// opp multiplier, signed
	localparam int W_DAC    = 16;	// dac code
	localparam int W_PROD   = W_COMP + W_MLT;	// pid sum times multiplier, full width

	// datapath words
	typedef logic signed [W_SAMPLE-1:0] sample_t;
	typedef logic signed [W_EP-1:0]     coef_t;	// setpoint and gains
	typedef logic signed [W_COMP-1:0]   comp_t;
	typedef logic        [W_DAC-1:0]    dac_code_t;	// straight binary dac code

	// config register map
	typedef enum logic [3:0] {
		CFG_SETPOINT    = 4'd0,
		CFG_P_COEF      = 4'd1,
		CFG_I_COEF      = 4'd2,
		CFG_D_COEF      = 4'd3,
		CFG_MULTIPLIER  = 4'd4,
		CFG_RIGHT_SHIFT = 4'd5,
		CFG_OUT_MIN     = 4'd6,
		CFG_OUT_MAX     = 4'd7,
		CFG_OUT_INIT    = 4'd8,
		CFG_LOCK_EN     = 4'd9,	// one bit per channel
		CFG_CLEAR       = 4'd10	// immediate, no update needed
	} cfg_addr_e;

endpackage

// File: source/dac_pkg.sv
package dac_pkg;

	// dac8568 frame timing
	localparam int W_FRAME      = 32;	// one input shift register load
	localparam int FRAME_CYCLES = 2 * W_FRAME;	// sclk at half of clk50
	localparam int GAP_CYCLES   = 2;	// min nsync high between frames
	localparam int W_BITCNT     = $clog2(FRAME_CYCLES);
	localparam int W_GAPCNT     = $clog2(GAP_CYCLES + 1);

	localparam logic [3:0] CMD_WRITE_UPDATE = 4'd3;	// write input reg n, update dac n

	// command word as the part reads it, db31 first
	typedef struct packed {
		logic [3:0]  prefix;	// always zero
		logic [3:0]  control;
		logic [3:0]  address;	// dac channel a..h
		logic [15:0] data;
		logic [3:0]  feature;	// only setup commands use it
	} dac_cmd_t;

	typedef union packed {
		dac_cmd_t           cmd;	// built field by field
		logic [W_FRAME-1:0] raw;	// shifted out msb first
	} dac_word_u;

	// internal reference on, static mode
	localparam dac_cmd_t CMD_REF_SETUP = '{
		prefix: 4'h0, control: 4'h8, address: 4'h0, data: 16'h0000, feature: 4'h1
	};

endpackage

// File: source/pid_cfg_if.sv
`timescale 1ns/1ps

interface pid_cfg_if import pid_pkg::*; ();

	// pid core settings
	coef_t setpoint;
	coef_t p_coef;
	coef_t i_coef;
	coef_t d_coef;
	logic [N_CH-1:0] clear;	// one cycle pulse per channel

	// output preprocessor settings
	logic signed [W_MLT-1:0] multiplier;
	logic [W_EP-1:0] right_shift;
	dac_code_t out_min;
	dac_code_t out_max;
	dac_code_t out_init;
	logic [N_CH-1:0] lock_en;	// level per channel

	modport ctrl (output setpoint, p_coef, i_coef, d_coef, clear,
		multiplier, right_shift, out_min, out_max, out_init, lock_en);
	modport core (input setpoint, p_coef, i_coef, d_coef, clear);
	modport opp (input multiplier, right_shift, out_min, out_max, out_init, lock_en);

endinterface

// File: source/pid_control.sv
`timescale 1ns/1ps

module pid_control import pid_pkg::*; (
	input  logic            clk50,
	input  logic            reset,
	input  logic            cfg_wr,	// one cycle write strobe
	input  cfg_addr_e       cfg_addr,
	input  logic [W_EP-1:0] cfg_data,
	input  logic            cfg_update,	// global commit, like module_update
	pid_cfg_if.ctrl         cfg
);

	// shadow copies, written by the register port
	coef_t setpoint_sh;
	coef_t p_coef_sh;
	coef_t i_coef_sh;
	coef_t d_coef_sh;
	logic signed [W_MLT-1:0] multiplier_sh;
	logic [W_EP-1:0] right_shift_sh;
	dac_code_t out_min_sh;
	dac_code_t out_max_sh;
	dac_code_t out_init_sh;
	logic [N_CH-1:0] lock_en_sh;

	always_ff @(posedge clk50) begin
		if (reset) begin
			setpoint_sh    <= '0;
			p_coef_sh      <= '0;
			i_coef_sh      <= '0;
			d_coef_sh      <= '0;
			multiplier_sh  <= '0;
			right_shift_sh <= '0;
			out_min_sh     <= '0;
			out_max_sh     <= '0;
			out_init_sh    <= '0;
			lock_en_sh     <= '0;
		end else if (cfg_wr) begin
			case (cfg_addr)
				CFG_SETPOINT:    setpoint_sh    <= cfg_data;
				CFG_P_COEF:      p_coef_sh      <= cfg_data;
				CFG_I_COEF:      i_coef_sh      <= cfg_data;
				CFG_D_COEF:      d_coef_sh      <= cfg_data;
				CFG_MULTIPLIER:  multiplier_sh  <= cfg_data[W_MLT-1:0];	// low bits, signed
				CFG_RIGHT_SHIFT: right_shift_sh <= cfg_data;
				CFG_OUT_MIN:     out_min_sh     <= cfg_data;
				CFG_OUT_MAX:     out_max_sh     <= cfg_data;
				CFG_OUT_INIT:    out_init_sh    <= cfg_data;
				CFG_LOCK_EN:     lock_en_sh     <= cfg_data[N_CH-1:0];
				default: ;	// clear handled below, rest unmapped
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// active copies, all committed on the same edge
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50) begin
		if (reset) begin
			cfg.setpoint    <= '0;
			cfg.p_coef      <= '0;
			cfg.i_coef      <= '0;
			cfg.d_coef      <= '0;
			cfg.multiplier  <= '0;
			cfg.right_shift <= '0;
			cfg.out_min     <= '0;
			cfg.out_max     <= '0;
			cfg.out_init    <= '0;
			cfg.lock_en     <= '0;
		end else if (cfg_update) begin
			cfg.setpoint    <= setpoint_sh;
			cfg.p_coef      <= p_coef_sh;
			cfg.i_coef      <= i_coef_sh;
			cfg.d_coef      <= d_coef_sh;
			cfg.multiplier  <= multiplier_sh;
			cfg.right_shift <= right_shift_sh;
			cfg.out_min     <= out_min_sh;
			cfg.out_max     <= out_max_sh;
			cfg.out_init    <= out_init_sh;
			cfg.lock_en     <= lock_en_sh;
		end
	end

	// clear write -> single pulse per set bit
	always_ff @(posedge clk50) begin
		if (reset)
			cfg.clear <= '0;
		else if (cfg_wr && cfg_addr == CFG_CLEAR)
			cfg.clear <= cfg_data[N_CH-1:0];
		else
			cfg.clear <= '0;
	end

endmodule

// File: source/pid_core.sv
`timescale 1ns/1ps

module pid_core import pid_pkg::*; (
	input  logic    clk50,
	input  logic    reset,
	input  sample_t sample,
	input  logic    sample_valid,
	input  logic    ch_clear,	// this channel's clear pulse
	pid_cfg_if.core cfg,
	output comp_t   sum,	// p*e + i*integral + d*de
	output logic    sum_valid	// one cycle after sample_valid
);

	comp_t error;	// setpoint - sample
	comp_t integral;
	comp_t integral_new;
	comp_t e_prev;	// error of last sample
	comp_t deriv;
	comp_t sum_next;

	////////////////////////////////////////////////////////////////////////////
	// combinational pid terms, all in full computation width
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		error        = comp_t'(cfg.setpoint) - comp_t'(sample);
		integral_new = integral + error;	// includes this sample
		deriv        = error - e_prev;
		sum_next     = comp_t'(cfg.p_coef) * error
			+ comp_t'(cfg.i_coef) * integral_new
			+ comp_t'(cfg.d_coef) * deriv;
	end

	// loop state
	always_ff @(posedge clk50) begin
		if (reset) begin
			integral  <= '0;
			e_prev    <= '0;
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= sample_valid;
			if (ch_clear) begin	// clear beats a sample in the same cycle
				integral <= '0;
				e_prev   <= '0;
			end else if (sample_valid) begin
				integral <= integral_new;
				e_prev   <= error;
			end
		end
	end

	// result word
	always_ff @(posedge clk50) begin
		if (sample_valid)
			sum <= sum_next;
	end

endmodule

// File: source/output_preprocessor.sv
`timescale 1ns/1ps

module output_preprocessor import pid_pkg::*; (
	input  logic      clk50,
	input  logic      reset,
	input  comp_t     sum,
	input  logic      sum_valid,
	input  logic      ch_lock,	// loop closed on this channel
	pid_cfg_if.opp    cfg,
	output dac_code_t code,
	output logic      code_valid	// one cycle after sum_valid
);

	logic signed [W_PROD-1:0] product;
	logic signed [W_PROD-1:0] scaled;
	logic signed [W_PROD-1:0] value;
	logic signed [W_PROD-1:0] init_ext;	// limits widened, read as unsigned
	logic signed [W_PROD-1:0] min_ext;
	logic signed [W_PROD-1:0] max_ext;
	dac_code_t code_next;

	always_comb begin
		init_ext = {{(W_PROD - W_DAC){1'b0}}, cfg.out_init};
		min_ext  = {{(W_PROD - W_DAC){1'b0}}, cfg.out_min};
		max_ext  = {{(W_PROD - W_DAC){1'b0}}, cfg.out_max};
		product  = W_PROD'(sum) * W_PROD'(cfg.multiplier);	// signed, cannot overflow
		scaled   = product >>> cfg.right_shift;
		value    = ch_lock ? init_ext + scaled : init_ext;	// unlocked parks at out_init
		// clamp, min checked first
		if (value < min_ext)
			code_next = cfg.out_min;
		else if (value > max_ext)
			code_next = cfg.out_max;
		else
			code_next = value[W_DAC-1:0];
	end

	always_ff @(posedge clk50) begin
		if (reset)
			code_valid <= 1'b0;
		else
			code_valid <= sum_valid;
	end

	always_ff @(posedge clk50) begin
		if (sum_valid)
			code <= code_next;
	end

endmodule

// File: source/dac_writer.sv
`timescale 1ns/1ps

module dac_writer import pid_pkg::*, dac_pkg::*; (
	input  logic      clk50,
	input  logic      reset,
	input  dac_code_t code [N_CH],	// one code per channel
	input  logic      code_valid [N_CH],
	output logic      dac_nsync,
	output logic      dac_sclk,
	output logic      dac_din	// changes on rising sclk, part samples on falling
);

	dac_code_t pend_code [N_CH];	// latest value wins
	logic      pend_flag [N_CH];
	logic      ref_pend;	// reference setup owed since reset

	logic [$clog2(N_CH)-1:0] sel_ch;	// lowest pending channel
	logic                    sel_valid;
	logic                    start;

	dac_word_u           word;
	logic [W_FRAME-1:0]  shift_reg;
	logic                busy;	// nsync low
	logic [W_BITCNT-1:0] bit_cnt;	// half sclk periods in frame
	logic [W_GAPCNT-1:0] gap_cnt;	// idle cycles still owed

	////////////////////////////////////////////////////////////////////////////
	// arbitration and command build
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		sel_valid = 1'b0;
		sel_ch    = '0;
		for (int i = N_CH - 1; i >= 0; i--) begin	// last hit is lowest index
			if (pend_flag[i]) begin
				sel_valid = 1'b1;
				sel_ch    = ($clog2(N_CH))'(i);
			end
		end
		if (ref_pend) begin
			word.cmd = CMD_REF_SETUP;
		end else begin
			word.cmd.prefix  = 4'h0;
			word.cmd.control = CMD_WRITE_UPDATE;
			word.cmd.address = 4'(sel_ch);
			word.cmd.data    = pend_code[sel_ch];
			word.cmd.feature = 4'h0;
		end
	end

	assign start = !busy && gap_cnt == '0 && (ref_pend || sel_valid);

	always_ff @(posedge clk50) begin
		for (int i = 0; i < N_CH; i++) begin
			if (code_valid[i])
				pend_code[i] <= code[i];
		end
	end

	always_ff @(posedge clk50) begin
		if (reset) begin
			ref_pend <= 1'b1;
			for (int i = 0; i < N_CH; i++)
				pend_flag[i] <= 1'b0;
		end else begin
			if (start)
				ref_pend <= 1'b0;
			for (int i = 0; i < N_CH; i++) begin
				if (code_valid[i])	// fresh code stays pending even if sent now
					pend_flag[i] <= 1'b1;
				else if (start && !ref_pend && sel_ch == i)
					pend_flag[i] <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// serial framing
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50) begin
		if (reset) begin
			busy      <= 1'b0;
			bit_cnt   <= '0;
			gap_cnt   <= '0;
			dac_nsync <= 1'b1;
			dac_sclk  <= 1'b0;
			dac_din   <= 1'b0;
		end else if (start) begin
			busy      <= 1'b1;
			bit_cnt   <= '0;
			dac_nsync <= 1'b0;
			dac_sclk  <= 1'b1;	// first rising edge carries db31
			dac_din   <= word.raw[W_FRAME-1];
		end else if (busy) begin
			if (bit_cnt == W_BITCNT'(FRAME_CYCLES - 1)) begin	// 32nd falling edge done
				busy      <= 1'b0;
				gap_cnt   <= W_GAPCNT'(GAP_CYCLES);
				dac_nsync <= 1'b1;
				dac_sclk  <= 1'b0;
				dac_din   <= 1'b0;
			end else begin
				bit_cnt  <= bit_cnt + 1'b1;
				dac_sclk <= ~dac_sclk;
				if (!dac_sclk)
					dac_din <= shift_reg[W_FRAME-1];
			end
		end else if (gap_cnt != '0) begin
			gap_cnt <= gap_cnt - 1'b1;
		end
	end

	// frame bits, msb leaves first
	always_ff @(posedge clk50) begin
		if (start)
			shift_reg <= word.raw << 1;
		else if (busy && !dac_sclk)
			shift_reg <= shift_reg << 1;
	end

endmodule

// File: source/pid_controller.sv
`timescale 1ns/1ps

module pid_controller import pid_pkg::*; (
	input  logic            clk50,	// 50 MHz system clock
	input  logic            reset,
	input  sample_t         sample_a,	// adc channel a
	input  sample_t         sample_b,	// adc channel b
	input  logic            sample_valid,	// shared strobe
	input  logic            cfg_wr,
	input  cfg_addr_e       cfg_addr,
	input  logic [W_EP-1:0] cfg_data,
	input  logic            cfg_update,
	output logic            dac_nsync,
	output logic            dac_sclk,
	output logic            dac_din
);

	sample_t   sample_in [N_CH];
	comp_t     pid_sum   [N_CH];
	logic      pid_valid [N_CH];
	dac_code_t opp_code  [N_CH];
	logic      opp_valid [N_CH];

	pid_cfg_if u_cfg ();	// committed settings

	assign sample_in[0] = sample_a;
	assign sample_in[1] = sample_b;

	pid_control u_pid_control (
		.clk50      (clk50),
		.reset      (reset),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.cfg_update (cfg_update),
		.cfg        (u_cfg)
	);

	////////////////////////////////////////////////////////////////////////////
	// per channel loop, channel i drives dac channel i
	////////////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < N_CH; i++) begin : g_ch
		pid_core u_pid_core (
			.clk50        (clk50),
			.reset        (reset),
			.sample       (sample_in[i]),
			.sample_valid (sample_valid),
			.ch_clear     (u_cfg.clear[i]),
			.cfg          (u_cfg),
			.sum          (pid_sum[i]),
			.sum_valid    (pid_valid[i])
		);

		output_preprocessor u_opp (
			.clk50      (clk50),
			.reset      (reset),
			.sum        (pid_sum[i]),
			.sum_valid  (pid_valid[i]),
			.ch_lock    (u_cfg.lock_en[i]),
			.cfg        (u_cfg),
			.code       (opp_code[i]),
			.code_valid (opp_valid[i])
		);
	end

	dac_writer u_dac_writer (
		.clk50      (clk50),
		.reset      (reset),
		.code       (opp_code),
		.code_valid (opp_valid),
		.dac_nsync  (dac_nsync),
		.dac_sclk   (dac_sclk),
		.dac_din    (dac_din)
	);

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk50,	// 50 MHz, 20 ns period
	output logic reset	// synchronous, active high
);

	initial begin
		clk50 = 1'b0;
		forever #10 clk50 = ~clk50;
	end

	// reset held over 16 rising edges, released between edges
	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk50);
		@(negedge clk50);
		reset = 1'b0;
	end

endmodule

// File: bench/pid_controller_asserts.sv
`timescale 1ns/1ps

module pid_controller_asserts (
	input logic clk50,
	input logic reset,
	input logic dac_nsync,
	input logic dac_sclk
);

	logic [7:0] low_cnt;	// cycles nsync has been low so far

	always_ff @(posedge clk50) begin
		if (reset || dac_nsync)
			low_cnt <= '0;
		else
			low_cnt <= low_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// serial pin rules
	////////////////////////////////////////////////////////////////////////////
	a_nsync_reset: assert property (@(posedge clk50) reset |=> dac_nsync)
		else $error("nsync was not high during reset or in the cycle after it");

	a_sclk_idle: assert property (@(posedge clk50) disable iff (reset)
		dac_nsync |-> !dac_sclk)
		else $error("sclk was high while nsync was high");

	// a frame never runs past 64 cycles
	a_frame_max: assert property (@(posedge clk50) disable iff (reset)
		!dac_nsync |-> low_cnt < 8'd64)
		else $error("nsync stayed low longer than 64 cycles");

	a_frame_len: assert property (@(posedge clk50) disable iff (reset)
		$rose(dac_nsync) |-> low_cnt == 8'd64)	// and never shorter
		else $error("nsync low time was not 64 cycles");

endmodule

bind pid_controller pid_controller_asserts u_asserts (
	.clk50     (clk50),
	.reset     (reset),
	.dac_nsync (dac_nsync),
	.dac_sclk  (dac_sclk)
);

// File: bench/tb_pid_controller.sv
`timescale 1ns/1ps

module tb_pid_controller import pid_pkg::*, dac_pkg::*; ();

	logic            clk50;
	logic            reset;
	sample_t         sample_a;
	sample_t         sample_b;
	logic            sample_valid;
	logic            cfg_wr;
	cfg_addr_e       cfg_addr;
	logic [W_EP-1:0] cfg_data;
	logic            cfg_update;
	logic            dac_nsync;
	logic            dac_sclk;
	logic            dac_din;

	logic [W_EP-1:0]    sh_reg  [16];	// model shadow registers
	logic [W_EP-1:0]    act_reg [16];	// model active registers
	longint             integ [N_CH];	// model integral per channel
	longint             eprev [N_CH];
	dac_code_t          last_code [N_CH];	// codes seen in the last frames
	dac_code_t          last_exp [N_CH];	// model codes of the last strobe
	int                 clamp_hits;
	int                 cycle;
	logic [W_FRAME-1:0] frames [$];	// decoded frames, oldest first
	logic [W_FRAME-1:0] rx_word;
	logic               sclk_prev;
	logic               nsync_prev;

	tb_clock u_clock (.clk50(clk50), .reset(reset));

	pid_controller u_pid_controller (
		.clk50        (clk50),
		.reset        (reset),
		.sample_a     (sample_a),
		.sample_b     (sample_b),
		.sample_valid (sample_valid),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_data     (cfg_data),
		.cfg_update   (cfg_update),
		.dac_nsync    (dac_nsync),
		.dac_sclk     (dac_sclk),
		.dac_din      (dac_din)
	);

	always @(posedge clk50) cycle <= cycle + 1;

	////////////////////////////////////////////////////////////////////////////
	// frame decoder, looks at the pins between clock edges
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk50) begin
		if (!dac_nsync && sclk_prev && !dac_sclk)	// falling sclk, part samples din
			rx_word = {rx_word[W_FRAME-2:0], dac_din};
		if (!nsync_prev && dac_nsync)	// rising nsync ends the frame
			frames.push_back(rx_word);
		sclk_prev  = dac_sclk;
		nsync_prev = dac_nsync;
	end

	task automatic stop_with_errors();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			stop_with_errors();
		end
	endtask

	function automatic int rand_range(int lo, int hi);
		return lo + int'($urandom % 32'(hi - lo + 1));
	endfunction

	// register port write, model follows the shadow and clear rules
	task automatic write_reg(cfg_addr_e addr, logic [W_EP-1:0] data);
		@(negedge clk50);
		cfg_wr   = 1'b1;
		cfg_addr = addr;
		cfg_data = data;
		if (addr == CFG_CLEAR) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				if (data[ch]) begin
					integ[ch] = 0;
					eprev[ch] = 0;
				end
			end
		end else begin
			sh_reg[addr] = data;
		end
		@(negedge clk50);
		cfg_wr = 1'b0;
	endtask

	task automatic commit_update();
		@(negedge clk50);
		cfg_update = 1'b1;
		act_reg    = sh_reg;	// every setting moves at once
		@(negedge clk50);
		cfg_update = 1'b0;
	endtask

	task automatic write_limits();
		int lo;
		int hi;
		lo = rand_range(0, 16383);
		hi = lo + rand_range(16384, 32767);
		write_reg(CFG_OUT_MIN, 16'(lo));
		write_reg(CFG_OUT_MAX, 16'(hi));
		write_reg(CFG_OUT_INIT, 16'(rand_range(lo, hi)));
	endtask

	// reference loop, pid then scale, offset and clamp in 128 bits
	task automatic model_step(int ch, sample_t smp, output dac_code_t code);
		longint              err;
		longint              pid;
		logic signed [127:0] val;
		logic signed [127:0] mlt;
		logic signed [127:0] init;
		logic signed [127:0] lo;
		logic signed [127:0] hi;
		err       = longint'($signed(act_reg[CFG_SETPOINT])) - longint'(smp);
		integ[ch] = integ[ch] + err;
		pid = longint'($signed(act_reg[CFG_P_COEF])) * err
			+ longint'($signed(act_reg[CFG_I_COEF])) * integ[ch]
			+ longint'($signed(act_reg[CFG_D_COEF])) * (err - eprev[ch]);
		eprev[ch] = err;
		mlt  = $signed(act_reg[CFG_MULTIPLIER][W_MLT-1:0]);
		init = {112'd0, act_reg[CFG_OUT_INIT]};
		lo   = {112'd0, act_reg[CFG_OUT_MIN]};
		hi   = {112'd0, act_reg[CFG_OUT_MAX]};
		val  = pid;
		val  = (val * mlt) >>> act_reg[CFG_RIGHT_SHIFT];
		if (act_reg[CFG_LOCK_EN][ch])
			val = init + val;
		else
			val = init;	// open loop parks at out_init
		if (val < lo) begin
			code = act_reg[CFG_OUT_MIN];
			clamp_hits++;
		end else if (val > hi) begin
			code = act_reg[CFG_OUT_MAX];
			clamp_hits++;
		end else begin
			code = val[W_DAC-1:0];
		end
	endtask

	// one strobe, then one frame per channel, strobes 200 cycles apart
	task automatic run_sample(string name, sample_t a, sample_t b);
		dac_code_t          exp_code [N_CH];
		logic [W_FRAME-1:0] word;
		int                 start;
		model_step(0, a, exp_code[0]);
		model_step(1, b, exp_code[1]);
		@(negedge clk50);
		start        = cycle;
		sample_a     = a;
		sample_b     = b;
		sample_valid = 1'b1;
		@(negedge clk50);
		sample_valid = 1'b0;
		for (int ch = 0; ch < N_CH; ch++) begin
			while (frames.size() == 0) @(posedge clk50);
			word = frames.pop_front();
			check(name, {4'h0, 4'h3, 4'(ch), exp_code[ch], 4'h0}, word);	// write and update
			last_code[ch] = word[19:4];
			last_exp[ch]  = exp_code[ch];
		end
		while (cycle - start < 200) @(negedge clk50);
	endtask

	// watchdog, strobes x spacing x period plus 10 us
	initial begin
		#((4 + 12 + 16 + 6) * 200 * 20 + 10_000);
		$display("timeout: the DUT did not deliver the expected frames in time");
		stop_with_errors();
	end

	initial begin
		logic [W_FRAME-1:0] word;
		int                 sp;
		sample_t            a;
		sample_t            b;
		dac_code_t          held [N_CH];
		void'($urandom(32'h3688_270b));
		sample_a     = '0;
		sample_b     = '0;
		sample_valid = 1'b0;
		cfg_wr       = 1'b0;
		cfg_addr     = CFG_SETPOINT;
		cfg_data     = '0;
		cfg_update   = 1'b0;
		cycle        = 0;
		clamp_hits   = 0;
		rx_word      = '0;
		sclk_prev    = 1'b0;
		nsync_prev   = 1'b1;
		for (int i = 0; i < 16; i++) begin
			sh_reg[i]  = '0;
			act_reg[i] = '0;
		end
		for (int ch = 0; ch < N_CH; ch++) begin
			integ[ch] = 0;
			eprev[ch] = 0;
		end
		@(negedge clk50);
		while (reset) @(negedge clk50);

		// reference setup comes first
		while (frames.size() == 0) @(posedge clk50);
		word = frames.pop_front();
		check("ref_setup", {4'h0, 4'h8, 4'h0, 16'h0000, 4'h1}, word);

		////////////////////////////////////////////////////////////////////////
		// open loop, random gains must not show
		////////////////////////////////////////////////////////////////////////
		write_reg(CFG_P_COEF, 16'($urandom));
		write_reg(CFG_I_COEF, 16'($urandom));
		write_reg(CFG_MULTIPLIER, 16'($urandom));
		write_reg(CFG_LOCK_EN, 16'h0);
		write_limits();
		commit_update();
		for (int n = 0; n < 4; n++) begin
			run_sample("unlocked", sample_t'($urandom), sample_t'($urandom));
			check("unlocked_init_a", act_reg[CFG_OUT_INIT], last_code[0]);
			check("unlocked_init_b", act_reg[CFG_OUT_INIT], last_code[1]);
		end

		// p only, big swings so some codes hit the limits
		for (int k = 0; k < 4; k++) begin
			write_reg(CFG_SETPOINT, 16'($urandom));
			write_reg(CFG_P_COEF, 16'(rand_range(-2047, 2047)));
			write_reg(CFG_I_COEF, 16'h0);
			write_reg(CFG_D_COEF, 16'h0);
			write_reg(CFG_MULTIPLIER, 16'(rand_range(-511, 511)));
			write_reg(CFG_RIGHT_SHIFT, 16'(rand_range(16, 26)));
			write_limits();
			write_reg(CFG_LOCK_EN, 16'h3);
			commit_update();
			for (int n = 0; n < 3; n++)
				run_sample("p_only", sample_t'($urandom), sample_t'($urandom));
		end
		check("p_only_clamp_seen", 64'd1, 64'(clamp_hits > 0));

		////////////////////////////////////////////////////////////////////////
		// full pid, integral builds up, one channel cleared halfway
		////////////////////////////////////////////////////////////////////////
		sp = rand_range(-8192, 8191);
		write_reg(CFG_CLEAR, 16'h3);
		write_reg(CFG_SETPOINT, 16'(sp));
		write_reg(CFG_P_COEF, 16'(rand_range(-32, 32)));
		write_reg(CFG_I_COEF, 16'(rand_range(-16, 16)));
		write_reg(CFG_D_COEF, 16'(rand_range(-64, 64)));
		write_reg(CFG_MULTIPLIER, 16'(rand_range(64, 511)));
		write_reg(CFG_RIGHT_SHIFT, 16'(rand_range(14, 18)));
		write_reg(CFG_OUT_MIN, 16'h0000);
		write_reg(CFG_OUT_MAX, 16'hffff);
		write_reg(CFG_OUT_INIT, 16'h8000);	// mid scale
		commit_update();
		for (int n = 0; n < 16; n++) begin
			if (n == 8)
				write_reg(CFG_CLEAR, 16'(1 << rand_range(0, 1)));
			run_sample("pid_integral", sample_t'(sp + rand_range(-4096, 4095)),
				sample_t'(sp + rand_range(-4096, 4095)));
		end

		// shadow writes stay hidden until the update pulse
		sp = rand_range(-8192, 8191);
		write_reg(CFG_SETPOINT, 16'(sp));
		write_reg(CFG_P_COEF, 16'(rand_range(-2047, 2047)));
		write_reg(CFG_I_COEF, 16'h0);
		write_reg(CFG_D_COEF, 16'h0);
		write_reg(CFG_RIGHT_SHIFT, 16'(rand_range(18, 20)));
		commit_update();
		a = sample_t'(sp + rand_range(-1024, 1023));
		b = sample_t'(sp + rand_range(-1024, 1023));
		run_sample("hold_base", a, b);
		held = last_exp;
		write_reg(CFG_P_COEF, 16'(rand_range(-2047, 2047)));
		write_reg(CFG_MULTIPLIER, 16'(rand_range(-511, 511)));
		write_reg(CFG_RIGHT_SHIFT, 16'(rand_range(16, 20)));
		write_reg(CFG_OUT_INIT, 16'(rand_range(16384, 49151)));
		write_reg(CFG_SETPOINT, 16'(sp + rand_range(-512, 511)));
		for (int n = 0; n < 2; n++) begin
			run_sample("no_update", a, b);
			check("no_update_a", held[0], last_code[0]);
			check("no_update_b", held[1], last_code[1]);
		end
		commit_update();
		for (int n = 0; n < 3; n++)
			run_sample("after_update", a, b);

		check("extra_frames", 64'd0, 64'(frames.size()));
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: filelist.f
source/pid_pkg.sv
source/dac_pkg.sv
source/pid_cfg_if.sv
source/pid_control.sv
source/pid_core.sv
source/output_preprocessor.sv
source/dac_writer.sv
source/pid_controller.sv
bench/tb_clock.sv
bench/pid_controller_asserts.sv
bench/tb_pid_controller.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := tb_pid_controller
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Done: errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
